// ==== oramCryptPkg.sv ====
//--------------------------------------------------------------------
// ORAM bucket encryption package
// Chunk geometry, keystream mixing constants and path direction type
//--------------------------------------------------------------------

package oramCryptPkg;

    //--------------------------------------------------------------------
    // Chunk and bucket geometry
    //--------------------------------------------------------------------

    // One chunk is one bus word
    parameter int ChunkWidth = 128;

    // IV field sits in the low bits of the header chunk
    parameter int IvWidth = 64;

    // Chunk 0 of each bucket is the header
    parameter int ChunksPerBucket = 4;

    // Direction flips after this many buckets
    parameter int BucketsPerPath = 3;

    typedef logic [ChunkWidth-1:0] chunk_t;

    //--------------------------------------------------------------------
    // Keystream mixing
    //--------------------------------------------------------------------

    // Golden ratio word repeated across the chunk
    parameter chunk_t MixConst = {(ChunkWidth / 32){32'h9e3779b9}};

    // Left rotate per round
    parameter int MixRotate = 13;

    //--------------------------------------------------------------------
    // Path direction
    //--------------------------------------------------------------------

    // Read moves DRAM to back end, write moves back end to DRAM
    typedef enum logic {
        PathRead,
        PathWrite
    } pathDir_t;

endpackage

// ==== chunkStreamIf.sv ====
//--------------------------------------------------------------------
// Chunk stream interface
// Valid/ready link carrying one chunk and a header flag
//--------------------------------------------------------------------

`timescale 1ns/1ps

interface chunkStreamIf;
    import oramCryptPkg::*;

    chunk_t data;
    logic   isHeader;
    logic   valid;
    logic   ready;

    // Producer side holds data while valid is up and ready is low
    modport source (
        output data,
        output isHeader,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  isHeader,
        input  valid,
        output ready
    );

endinterface

// ==== syncFifo.sv ====
//--------------------------------------------------------------------
// Synchronous FIFO
// Circular buffer with valid/ready on both sides, any payload type
//--------------------------------------------------------------------

`timescale 1ns/1ps

module syncFifo #(
    parameter type payload_t = logic [31:0],
    parameter int  Depth     = 8
) (
    input  logic     Clock,
    input  logic     rstN,
    input  payload_t inData,
    input  logic     inValid,
    output logic     inReady,
    output payload_t outData,
    output logic     outValid,
    input  logic     outReady
);

    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    payload_t              mem [Depth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  push;
    logic                  pop;

    assign inReady  = (count != CountWidth'(Depth));
    assign outValid = (count != '0);
    assign outData  = mem[rdPtr];

    assign push = inValid & inReady;
    assign pop  = outValid & outReady;

    // Payload write into the slot at the write pointer
    always_ff @(posedge Clock) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    // Pointers wrap at Depth, so Depth need not be a power of two
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CountWidth'(push) - CountWidth'(pop);
        end
    end

endmodule

// ==== bucketDecode.sv ====
//--------------------------------------------------------------------
// Bucket decode
// Tracks chunk position in the bucket and forks data and seed streams
//--------------------------------------------------------------------

`timescale 1ns/1ps

module bucketDecode #(
    parameter int ChunksPerBucket = oramCryptPkg::ChunksPerBucket
) (
    input  logic                Clock,
    input  logic                rstN,
    input  oramCryptPkg::chunk_t dramRdData,
    input  logic                dramRdValid,
    output logic                dramRdReady,
    input  oramCryptPkg::chunk_t beWrData,
    input  logic                beWrValid,
    output logic                beWrReady,
    chunkStreamIf.source        chunkOut,
    chunkStreamIf.source        seedOut
);
    import oramCryptPkg::*;

    localparam int IndexWidth = (ChunksPerBucket > 1) ? $clog2(ChunksPerBucket) : 1;

    chunk_t                inData;
    logic                  inValid;
    logic                  bothReady;
    logic                  accept;
    logic                  isHeader;
    logic [IndexWidth-1:0] chunkIndex;
    logic [IvWidth-1:0]    bucketIv;

    //--------------------------------------------------------------------
    // Input select
    //--------------------------------------------------------------------

    // Back-end write data wins when both sides present a chunk
    assign inData  = beWrValid ? beWrData : dramRdData;
    assign inValid = beWrValid | dramRdValid;

    assign bothReady = chunkOut.ready & seedOut.ready;
    assign accept    = inValid & bothReady;

    assign beWrReady   = bothReady;
    assign dramRdReady = bothReady & ~beWrValid;

    //--------------------------------------------------------------------
    // Bucket position and IV
    //--------------------------------------------------------------------

    assign isHeader = (chunkIndex == '0);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            chunkIndex <= '0;
        end else if (accept) begin
            if (chunkIndex == IndexWidth'(ChunksPerBucket - 1)) begin
                chunkIndex <= '0;
            end else begin
                chunkIndex <= chunkIndex + 1'b1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (accept && isHeader) begin
            bucketIv <= inData[IvWidth-1:0];
        end
    end

    //--------------------------------------------------------------------
    // Forks
    //--------------------------------------------------------------------

    // Each link only fires when the other can take its copy too
    assign chunkOut.data     = inData;
    assign chunkOut.isHeader = isHeader;
    assign chunkOut.valid    = inValid & seedOut.ready;

    // Header seeds straight from the incoming IV since its index is zero
    assign seedOut.data = isHeader ? chunk_t'(inData[IvWidth-1:0])
                                   : chunk_t'(bucketIv) + chunk_t'(chunkIndex);
    assign seedOut.isHeader = isHeader;
    assign seedOut.valid    = inValid & chunkOut.ready;

endmodule

// ==== keystreamExecute.sv ====
//--------------------------------------------------------------------
// Keystream execute
// Three-stage stallable mixing pipeline from seed to keystream word
//--------------------------------------------------------------------

`timescale 1ns/1ps

module keystreamExecute #(
    parameter oramCryptPkg::chunk_t Key = '1
) (
    input  logic                 Clock,
    input  logic                 rstN,
    chunkStreamIf.sink           seedIn,
    output oramCryptPkg::chunk_t keyOut,
    output logic                 keyValid,
    input  logic                 keyReady
);
    import oramCryptPkg::*;

    localparam int Stages = 3;

    chunk_t              stageData [Stages];
    logic [Stages-1:0]   stageValid;
    logic                stall;

    // One round: key XOR, left rotate, add constant
    function automatic chunk_t mixRound(input chunk_t x);
        chunk_t keyed;
        chunk_t rotated;
        keyed   = x ^ Key;
        rotated = {keyed[ChunkWidth-1-MixRotate:0],
                   keyed[ChunkWidth-1:ChunkWidth-MixRotate]};
        return rotated + MixConst;
    endfunction

    //--------------------------------------------------------------------
    // Flow control
    //--------------------------------------------------------------------

    // Whole pipe freezes while the last stage is blocked
    assign stall = stageValid[Stages-1] & ~keyReady;

    assign seedIn.ready = ~stall;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            stageValid <= '0;
        end else if (!stall) begin
            stageValid <= {stageValid[Stages-2:0], seedIn.valid};
        end
    end

    //--------------------------------------------------------------------
    // Rounds
    //--------------------------------------------------------------------

    always_ff @(posedge Clock) begin
        if (!stall) begin
            stageData[0] <= mixRound(seedIn.data);
            for (int i = 1; i < Stages; i++) begin
                stageData[i] <= mixRound(stageData[i-1]);
            end
        end
    end

    assign keyOut   = stageData[Stages-1];
    assign keyValid = stageValid[Stages-1];

endmodule

// ==== cipherResult.sv ====
//--------------------------------------------------------------------
// Cipher result
// Pairs chunks with keystream, XORs, restores IV and routes by path
//--------------------------------------------------------------------

`timescale 1ns/1ps

module cipherResult #(
    parameter int ChunksPerBucket = oramCryptPkg::ChunksPerBucket,
    parameter int BucketsPerPath  = oramCryptPkg::BucketsPerPath
) (
    input  logic                 Clock,
    input  logic                 rstN,
    chunkStreamIf.sink           chunkIn,
    input  oramCryptPkg::chunk_t keyIn,
    input  logic                 keyValid,
    output logic                 keyReady,
    output oramCryptPkg::chunk_t dramWrData,
    output logic                 dramWrValid,
    input  logic                 dramWrReady,
    output oramCryptPkg::chunk_t beRdData,
    output logic                 beRdValid,
    input  logic                 beRdReady
);
    import oramCryptPkg::*;

    localparam int FifoDepth  = 8;
    localparam int PathChunks = ChunksPerBucket * BucketsPerPath;
    localparam int PathWidth  = (PathChunks > 1) ? $clog2(PathChunks) : 1;

    typedef struct packed {
        logic   isHeader;
        chunk_t data;
    } taggedChunk_t;

    taggedChunk_t         dataHead;
    logic                 dataHeadValid;
    chunk_t               keyHead;
    logic                 keyHeadValid;
    chunk_t               xorRes;
    chunk_t               result;
    logic                 resultValid;
    logic                 outReady;
    logic                 pop;
    pathDir_t             pathDir;
    logic [PathWidth-1:0] pathCount;

    //--------------------------------------------------------------------
    // Data and keystream queues
    //--------------------------------------------------------------------

    syncFifo #(.payload_t(taggedChunk_t), .Depth(FifoDepth)) dataFifo (
        .Clock    (Clock),
        .rstN     (rstN),
        .inData   ('{isHeader: chunkIn.isHeader, data: chunkIn.data}),
        .inValid  (chunkIn.valid),
        .inReady  (chunkIn.ready),
        .outData  (dataHead),
        .outValid (dataHeadValid),
        .outReady (keyHeadValid & outReady)
    );

    // Deeper than the mixing pipe so in-flight seeds always land
    syncFifo #(.payload_t(chunk_t), .Depth(FifoDepth)) keyFifo (
        .Clock    (Clock),
        .rstN     (rstN),
        .inData   (keyIn),
        .inValid  (keyValid),
        .inReady  (keyReady),
        .outData  (keyHead),
        .outValid (keyHeadValid),
        .outReady (dataHeadValid & outReady)
    );

    //--------------------------------------------------------------------
    // Combine
    //--------------------------------------------------------------------

    assign xorRes      = dataHead.data ^ keyHead;
    assign resultValid = dataHeadValid & keyHeadValid;

    // Header keeps its plaintext IV in the low bits
    assign result = dataHead.isHeader ? {xorRes[ChunkWidth-1:IvWidth],
                                         dataHead.data[IvWidth-1:0]}
                                      : xorRes;

    //--------------------------------------------------------------------
    // Path direction and routing
    //--------------------------------------------------------------------

    assign outReady = (pathDir == PathWrite) ? dramWrReady : beRdReady;
    assign pop      = resultValid & outReady;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pathDir   <= PathRead;
            pathCount <= '0;
        end else if (pop) begin
            if (pathCount == PathWidth'(PathChunks - 1)) begin
                pathCount <= '0;
                pathDir   <= (pathDir == PathRead) ? PathWrite : PathRead;
            end else begin
                pathCount <= pathCount + 1'b1;
            end
        end
    end

    assign dramWrData  = result;
    assign beRdData    = result;
    assign dramWrValid = resultValid & (pathDir == PathWrite);
    assign beRdValid   = resultValid & (pathDir == PathRead);

endmodule

// ==== oramCrypt.sv ====
//--------------------------------------------------------------------
// ORAM bucket encryption stage
// Decode, keystream pipeline and result routing between DRAM and back end
//--------------------------------------------------------------------

`timescale 1ns/1ps

module oramCrypt #(
    parameter oramCryptPkg::chunk_t Key = '1,
    parameter int ChunksPerBucket = oramCryptPkg::ChunksPerBucket,
    parameter int BucketsPerPath  = oramCryptPkg::BucketsPerPath
) (
    input  logic                 Clock,
    input  logic                 rstN,

    // DRAM read data in, back-end write data in
    input  oramCryptPkg::chunk_t dramRdData,
    input  logic                 dramRdValid,
    output logic                 dramRdReady,
    input  oramCryptPkg::chunk_t beWrData,
    input  logic                 beWrValid,
    output logic                 beWrReady,

    // DRAM write data out, back-end read data out
    output oramCryptPkg::chunk_t dramWrData,
    output logic                 dramWrValid,
    input  logic                 dramWrReady,
    output oramCryptPkg::chunk_t beRdData,
    output logic                 beRdValid,
    input  logic                 beRdReady
);
    import oramCryptPkg::*;

    chunk_t keyData;
    logic   keyValid;
    logic   keyReady;

    chunkStreamIf dataLink ();
    chunkStreamIf seedLink ();

    bucketDecode #(.ChunksPerBucket(ChunksPerBucket)) decode_i (
        .Clock       (Clock),
        .rstN        (rstN),
        .dramRdData  (dramRdData),
        .dramRdValid (dramRdValid),
        .dramRdReady (dramRdReady),
        .beWrData    (beWrData),
        .beWrValid   (beWrValid),
        .beWrReady   (beWrReady),
        .chunkOut    (dataLink.source),
        .seedOut     (seedLink.source)
    );

    keystreamExecute #(.Key(Key)) execute_i (
        .Clock    (Clock),
        .rstN     (rstN),
        .seedIn   (seedLink.sink),
        .keyOut   (keyData),
        .keyValid (keyValid),
        .keyReady (keyReady)
    );

    cipherResult #(
        .ChunksPerBucket (ChunksPerBucket),
        .BucketsPerPath  (BucketsPerPath)
    ) result_i (
        .Clock       (Clock),
        .rstN        (rstN),
        .chunkIn     (dataLink.sink),
        .keyIn       (keyData),
        .keyValid    (keyValid),
        .keyReady    (keyReady),
        .dramWrData  (dramWrData),
        .dramWrValid (dramWrValid),
        .dramWrReady (dramWrReady),
        .beRdData    (beRdData),
        .beRdValid   (beRdValid),
        .beRdReady   (beRdReady)
    );

endmodule

// ==== oramCrypt_props.sv ====
//--------------------------------------------------------------------
// ORAM bucket encryption output properties
// Handshake rules on the DRAM write and back-end read outputs
//--------------------------------------------------------------------

`timescale 1ns/1ps

module oramCryptProps (
    input logic                 Clock,
    input logic                 rstN,
    input oramCryptPkg::chunk_t dramWrData,
    input logic                 dramWrValid,
    input logic                 dramWrReady,
    input oramCryptPkg::chunk_t beRdData,
    input logic                 beRdValid,
    input logic                 beRdReady
);

    // One path direction at a time
    onePortValid: assert property (@(posedge Clock) disable iff (!rstN)
        !(dramWrValid && beRdValid))
        else $error("dramWrValid and beRdValid high in the same cycle");

    dramWrHold: assert property (@(posedge Clock) disable iff (!rstN)
        dramWrValid && !dramWrReady |=> dramWrValid && $stable(dramWrData))
        else $error("DRAM write output changed while stalled");

    beRdHold: assert property (@(posedge Clock) disable iff (!rstN)
        beRdValid && !beRdReady |=> beRdValid && $stable(beRdData))
        else $error("Back-end read output changed while stalled");

    // Reset leaves both outputs idle
    idleAfterReset: assert property (@(posedge Clock)
        $rose(rstN) |-> !dramWrValid && !beRdValid)
        else $error("Output valid in the first cycle after reset");

endmodule

// ==== oramCrypt_tb.sv ====
//--------------------------------------------------------------------
// ORAM bucket encryption testbench
// Table-driven paths checked against a model of the mixing rule
//--------------------------------------------------------------------

`timescale 1ns/1ps

module oramCrypt_tb;
    import oramCryptPkg::*;

    localparam int     NumPaths  = 4;
    localparam int     NumRows   = NumPaths * BucketsPerPath;
    localparam int     NumChunks = NumRows * ChunksPerBucket;
    localparam int     MaxCycles = NumChunks * 64 + 64;
    // DUT runs with its default key of all ones
    localparam chunk_t Key       = '1;

    logic   Clock;
    logic   rstN;
    chunk_t dramRdData;
    logic   dramRdValid;
    logic   dramRdReady;
    chunk_t beWrData;
    logic   beWrValid;
    logic   beWrReady;
    chunk_t dramWrData;
    logic   dramWrValid;
    logic   dramWrReady;
    chunk_t beRdData;
    logic   beRdValid;
    logic   beRdReady;

    // Stimulus table, one row per bucket
    pathDir_t           rowDir  [NumRows];
    logic [IvWidth-1:0] rowIv   [NumRows];
    string              rowName [NumRows];
    chunk_t             rowIn   [NumRows][ChunksPerBucket];
    chunk_t             rowExp  [NumRows][ChunksPerBucket];

    chunk_t   expQ  [$];
    pathDir_t dirQ  [$];
    string    nameQ [$];
    int       errors;
    int       checks;
    int       cycles;
    bit       randomReady;

    oramCrypt dut_i (.*);

    bind oramCrypt oramCryptProps props_i (.*);

    //--------------------------------------------------------------------
    // Reference model
    //--------------------------------------------------------------------

    // Three rounds of key XOR, rotate left and constant add
    function automatic chunk_t keystreamOf(input chunk_t seed);
        chunk_t x;
        x = seed;
        for (int r = 0; r < 3; r++) begin
            x = x ^ Key;
            x = (x << MixRotate) | (x >> (ChunkWidth - MixRotate));
            x = x + MixConst;
        end
        return x;
    endfunction

    function automatic chunk_t cryptChunk(input chunk_t data, input logic [IvWidth-1:0] iv,
                                          input int idx);
        chunk_t res;
        res = data ^ keystreamOf(chunk_t'(iv) + chunk_t'(idx));
        // IV travels in clear
        if (idx == 0) begin
            res[IvWidth-1:0] = data[IvWidth-1:0];
        end
        return res;
    endfunction

    function automatic chunk_t randomChunk();
        chunk_t c;
        for (int w = 0; w < ChunkWidth / 32; w++) begin
            c[w*32 +: 32] = $urandom;
        end
        return c;
    endfunction

    task automatic buildTable();
        for (int r = 0; r < NumRows; r++) begin
            int     p;
            int     src;
            chunk_t c;
            p = r / BucketsPerPath;
            src = r - BucketsPerPath;
            c = randomChunk();
            rowDir[r] = (p % 2 == 0) ? PathRead : PathWrite;
            rowIv[r] = c[IvWidth-1:0];
            if (p == 2) begin
                // Ciphertext of path 1 read back must give its plaintext
                rowIv[r] = rowIv[src];
                rowName[r] = $sformatf("path%0d bucket%0d roundtrip", p, r % BucketsPerPath);
                for (int k = 0; k < ChunksPerBucket; k++) begin
                    rowIn[r][k] = rowExp[src][k];
                    rowExp[r][k] = rowIn[src][k];
                end
            end else begin
                rowName[r] = $sformatf("path%0d bucket%0d", p, r % BucketsPerPath);
                for (int k = 0; k < ChunksPerBucket; k++) begin
                    rowIn[r][k] = randomChunk();
                    if (k == 0) begin
                        rowIn[r][k][IvWidth-1:0] = rowIv[r];
                    end
                    rowExp[r][k] = cryptChunk(rowIn[r][k], rowIv[r], k);
                end
            end
        end
    endtask

    //--------------------------------------------------------------------
    // Drive and check
    //--------------------------------------------------------------------

    task automatic sendChunk(input pathDir_t dir, input chunk_t data);
        dramRdValid = (dir == PathRead);
        beWrValid = (dir == PathWrite);
        dramRdData = data;
        beWrData = data;
        @(negedge Clock);
        while (!((dir == PathRead) ? dramRdReady : beWrReady)) begin
            @(negedge Clock);
        end
        @(posedge Clock);
        #2;
    endtask

    task automatic checkOutput(input pathDir_t dir, input chunk_t data);
        chunk_t   exp;
        pathDir_t expDir;
        string    name;
        if (expQ.size() == 0) begin
            errors++;
            $display("Output chunk appeared with no chunk outstanding");
        end else begin
            exp = expQ.pop_front();
            expDir = dirQ.pop_front();
            name = nameQ.pop_front();
            checks++;
            assert (dir == expDir) else begin
                errors++;
                $display("[ERROR] %s: expected port %s, actual port %s",
                         name, expDir.name(), dir.name());
            end
            assert (data == exp) else begin
                errors++;
                $display("[ERROR] %s: expected %h, actual %h", name, exp, data);
            end
        end
    endtask

    // Inputs only move 2 ns after the edge, so the negedge view is what the edge takes
    always @(negedge Clock) begin
        if (rstN) begin
            if (dramWrValid && dramWrReady) begin
                checkOutput(PathWrite, dramWrData);
            end
            if (beRdValid && beRdReady) begin
                checkOutput(PathRead, beRdData);
            end
        end
    end

    always @(posedge Clock) begin
        #2;
        if (randomReady) begin
            dramWrReady = ($urandom % 4) != 0;
            beRdReady = ($urandom % 4) != 0;
        end
    end

    //--------------------------------------------------------------------
    // Clock, timeout and main sequence
    //--------------------------------------------------------------------

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    initial begin
        cycles = 0;
        while (cycles < MaxCycles) begin
            @(posedge Clock);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d chunks never came out", cycles, expQ.size());
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hde0e723d));
        rstN = 1'b0;
        dramRdData = '0;
        dramRdValid = 1'b0;
        beWrData = '0;
        beWrValid = 1'b0;
        dramWrReady = 1'b1;
        beRdReady = 1'b1;
        randomReady = 1'b0;
        errors = 0;
        checks = 0;
        buildTable();

        repeat (10) @(posedge Clock);
        #2;
        rstN = 1'b1;
        @(negedge Clock);
        assert (!dramWrValid && !beRdValid) else begin
            errors++;
            $display("An output valid was high right after reset");
        end
        @(posedge Clock);
        #2;

        for (int r = 0; r < NumRows; r++) begin
            // Last two paths run with random back-pressure
            if (r == 2 * BucketsPerPath) begin
                randomReady = 1'b1;
            end
            for (int k = 0; k < ChunksPerBucket; k++) begin
                expQ.push_back(rowExp[r][k]);
                dirQ.push_back(rowDir[r]);
                nameQ.push_back($sformatf("%s chunk%0d", rowName[r], k));
                sendChunk(rowDir[r], rowIn[r][k]);
            end
        end
        dramRdValid = 1'b0;
        beWrValid = 1'b0;

        while (expQ.size() != 0) begin
            @(posedge Clock);
        end
        // Idle tail catches stray outputs
        repeat (20) @(posedge Clock);

        $display("Checked %0d chunks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== oramCrypt.f ====
oramCryptPkg.sv
chunkStreamIf.sv
syncFifo.sv
bucketDecode.sv
keystreamExecute.sv
cipherResult.sv
oramCrypt.sv
oramCrypt_props.sv
oramCrypt_tb.sv

// ==== Makefile ====
# Verilator build and run for the ORAM bucket encryption stage

VERILATOR ?= verilator
TOP       ?= oramCrypt_tb
FILELIST  ?= oramCrypt.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BIN     := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

# Passes only if the testbench printed its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(MDIR)
